// File: mips.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/instruction_fetch.sv
verilog/register_file.sv
verilog/instruction_decode.sv
verilog/execution.sv
verilog/write_back.sv
verilog/mips.sv
tests/mips_tb.sv

// File: tests/mips_tb.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int TIMEOUT_CYCLES = 2000;   // Six short programs plus byte loading

    logic        i_clock;
    logic        i_rst;
    logic        i_pc_reset;
    logic        i_delete_program;
    logic        i_load_program_write_enable;
    logic [7:0]  i_load_program_byte;
    logic [4:0]  i_debug_read_reg_address;
    logic [31:0] o_debug_read_reg;
    logic        o_is_program_end;

    logic [31:0] prog [$];                  // Program words, loaded MSB first
    int          cycle_count;

    mips DUT (
        .o_debug_read_reg            (o_debug_read_reg),
        .o_is_program_end            (o_is_program_end),
        .i_debug_read_reg_address    (i_debug_read_reg_address),
        .i_load_program_byte         (i_load_program_byte),
        .i_load_program_write_enable (i_load_program_write_enable),
        .i_delete_program            (i_delete_program),
        .i_pc_reset                  (i_pc_reset),
        .i_rst                       (i_rst),
        .i_clock                     (i_clock)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Watchdog
    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: no program end after %0d cycles, simulation stopped", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] halt_word();
        return {`MIPS_OP_HALT, 26'd0};
    endfunction

    // ------------------------------
    // Check and debug read
    // ------------------------------
    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                     test_name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic expect_register(input string test_name, input logic [4:0] addr,
                                   input logic [31:0] expected);
        @(negedge i_clock);
        i_debug_read_reg_address = addr;
        #1;                                  // Combinational read settles
        check_value($sformatf("%s r%0d", test_name, addr), expected, o_debug_read_reg);
    endtask

    // ------------------------------
    // Program control
    // ------------------------------
    task automatic wait_for_end();
        do begin
            @(negedge i_clock);
        end while (!o_is_program_end);      // Watchdog bounds this
    endtask

    // Delete, load byte by byte under PC reset, then run
    task automatic load_and_run();
        @(negedge i_clock);
        i_pc_reset       = 1'b1;
        i_delete_program = 1'b1;
        @(negedge i_clock);
        i_delete_program = 1'b0;
        foreach (prog[w]) begin
            for (int b = 0; b < 4; b++) begin
                i_load_program_write_enable = 1'b1;
                i_load_program_byte = prog[w][31 - 8*b -: 8];   // MSB first
                @(negedge i_clock);
            end
        end
        i_load_program_write_enable = 1'b0;
        i_pc_reset = 1'b0;
        wait_for_end();
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic arith_rtype();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] diff;
        a = $urandom & 32'h7fff;
        b = ($urandom & 32'h7fff) | 32'h8000;  // Top bit set, so a < b
        diff = a - b;
        prog.delete();
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd1, 5'd0, a[15:0]));
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd2, 5'd0, b[15:0]));
        prog.push_back(rtype_word(`MIPS_FN_ADDU, 5'd3, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_SUBU, 5'd4, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_AND, 5'd5, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_OR, 5'd6, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_XOR, 5'd7, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_SLT, 5'd8, 5'd1, 5'd2));
        prog.push_back(rtype_word(`MIPS_FN_SLT, 5'd9, 5'd4, 5'd1));  // r4 is negative
        prog.push_back(rtype_word(`MIPS_FN_SLT, 5'd10, 5'd1, 5'd4));
        prog.push_back(halt_word());
        load_and_run();
        expect_register("arith_rtype", 5'd3, a + b);
        expect_register("arith_rtype", 5'd4, diff);
        expect_register("arith_rtype", 5'd5, a & b);
        expect_register("arith_rtype", 5'd6, a | b);
        expect_register("arith_rtype", 5'd7, a ^ b);
        expect_register("arith_rtype", 5'd8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_register("arith_rtype", 5'd9, ($signed(diff) < $signed(a)) ? 32'd1 : 32'd0);
        expect_register("arith_rtype", 5'd10, ($signed(a) < $signed(diff)) ? 32'd1 : 32'd0);
    endtask

    task automatic immediates();
        prog.delete();
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h1234));
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd2, 5'd1, 16'hfff0));  // -16
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd3, 5'd0, 16'h8000));
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd4, 5'd0, 16'h8001));
        prog.push_back(itype_word(`MIPS_OP_ANDI, 5'd5, 5'd3, 16'hf0f0));
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd0, 5'd1, 16'h0005));  // r0 stays 0
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd0, 5'd0, 16'hffff));
        prog.push_back(rtype_word(`MIPS_FN_OR, 5'd6, 5'd0, 5'd0));
        prog.push_back(halt_word());
        load_and_run();
        expect_register("immediates", 5'd1, 32'h0000_1234);
        expect_register("immediates", 5'd2, 32'h0000_1224);
        expect_register("immediates", 5'd3, 32'hffff_8000);
        expect_register("immediates", 5'd4, 32'h0000_8001);
        expect_register("immediates", 5'd5, 32'h0000_8000);
        expect_register("immediates", 5'd0, 32'h0);
        expect_register("immediates", 5'd6, 32'h0);
    endtask

    task automatic forwarding_chain();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] r4;
        logic [31:0] r7;
        x = $urandom & 32'hffff;
        y = $urandom & 32'hffff;
        r4 = x ^ (2 * x);                   // x minus nothing, see chain below
        r7 = y + 32'h0f0f;
        prog.delete();
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd1, 5'd0, x[15:0]));
        prog.push_back(rtype_word(`MIPS_FN_ADDU, 5'd2, 5'd1, 5'd1));   // Back to back
        prog.push_back(rtype_word(`MIPS_FN_SUBU, 5'd3, 5'd2, 5'd1));
        prog.push_back(rtype_word(`MIPS_FN_XOR, 5'd4, 5'd3, 5'd2));
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd5, 5'd0, y[15:0]));
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd6, 5'd0, 16'h0f0f));
        prog.push_back(rtype_word(`MIPS_FN_ADDU, 5'd7, 5'd5, 5'd6));   // r5 two back
        prog.push_back(rtype_word(`MIPS_FN_AND, 5'd8, 5'd7, 5'd4));
        // Same register rewritten, youngest value must win
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd9, 5'd0, 16'd10));
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd9, 5'd9, 16'd1));
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd9, 5'd9, 16'd1));
        prog.push_back(rtype_word(`MIPS_FN_ADDU, 5'd10, 5'd9, 5'd9));
        prog.push_back(halt_word());
        load_and_run();
        expect_register("forwarding", 5'd2, 2 * x);
        expect_register("forwarding", 5'd3, x);
        expect_register("forwarding", 5'd4, r4);
        expect_register("forwarding", 5'd7, r7);
        expect_register("forwarding", 5'd8, r7 & r4);
        expect_register("forwarding", 5'd9, 32'd12);
        expect_register("forwarding", 5'd10, 32'd24);
    endtask

    task automatic halt_stops_fetch();
        prog.delete();
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd1, 5'd0, 16'h0011));
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd2, 5'd0, 16'h0022));
        prog.push_back(halt_word());
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd3, 5'd0, 16'h0033)); // Never runs
        prog.push_back(rtype_word(`MIPS_FN_ADDU, 5'd2, 5'd1, 5'd2));
        load_and_run();
        for (int i = 0; i < 6; i++) begin
            @(negedge i_clock);
            check_value("halt end flag", 32'd1, {31'd0, o_is_program_end});  // Sticky
        end
        expect_register("halt", 5'd1, 32'h11);
        expect_register("halt", 5'd2, 32'h22);
        expect_register("halt", 5'd3, 32'h0);
    endtask

    task automatic pc_reset_rerun();
        @(negedge i_clock);
        i_pc_reset = 1'b1;
        @(negedge i_clock);
        check_value("pc_reset end flag", 32'd0, {31'd0, o_is_program_end});
        expect_register("pc_reset cleared", 5'd1, 32'h0);
        @(negedge i_clock);
        i_pc_reset = 1'b0;
        wait_for_end();                     // Same program, no reload
        expect_register("rerun", 5'd1, 32'h11);
        expect_register("rerun", 5'd3, 32'h0);
        expect_register("rerun", 5'd2, 32'h22);
    endtask

    task automatic delete_and_reload();
        prog.delete();
        prog.push_back(itype_word(`MIPS_OP_ORI, 5'd5, 5'd0, 16'h0a5a));
        prog.push_back(itype_word(`MIPS_OP_ADDIU, 5'd6, 5'd5, 16'hffff));
        prog.push_back(halt_word());
        load_and_run();
        expect_register("reload", 5'd1, 32'h0);   // Old program left nothing
        expect_register("reload", 5'd2, 32'h0);
        expect_register("reload", 5'd5, 32'h0000_0a5a);
        expect_register("reload", 5'd6, 32'h0000_0a59);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        i_clock                     = 1'b0;
        i_rst                       = 1'b1;
        i_pc_reset                  = 1'b0;
        i_delete_program            = 1'b0;
        i_load_program_write_enable = 1'b0;
        i_load_program_byte         = '0;
        i_debug_read_reg_address    = '0;
        cycle_count                 = 0;
        void'($urandom(95));
        repeat (4) @(negedge i_clock);
        i_rst = 1'b0;
        arith_rtype();
        immediates();
        forwarding_chain();
        halt_stops_fetch();
        pc_reset_rerun();
        delete_and_reload();
        $display("Test passed");
        $finish;
    end

endmodule

// File: verilog/mips.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips (
    output logic [`MIPS_NB_DATA-1:0]        o_debug_read_reg,
    output logic                            o_is_program_end,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_debug_read_reg_address,
    input  logic [`MIPS_NB_BYTE-1:0]        i_load_program_byte,
    input  logic                            i_load_program_write_enable,
    input  logic                            i_delete_program,
    input  logic                            i_pc_reset,
    input  logic                            i_rst,
    input  logic                            i_clock
);

    // ------------------------------
    // Stage boundaries
    // ------------------------------
    mips_pkg::if_id_t   if_id;
    mips_pkg::id_ex_t   id_ex;
    mips_pkg::ex_wb_t   ex_wb;
    mips_pkg::reg_wr_t  ex_fwd;     // Execute result, combinational
    mips_pkg::reg_wr_t  wb_wr;      // Register file write and second source

    instruction_fetch u_instruction_fetch (
        .i_clock                        (i_clock),
        .i_rst                          (i_rst),
        .i_pc_reset                     (i_pc_reset),
        .i_delete_program               (i_delete_program),
        .i_load_program_write_enable    (i_load_program_write_enable),
        .i_load_program_byte            (i_load_program_byte),
        .o_if_id                        (if_id)
    );

    instruction_decode u_instruction_decode (
        .i_clock                    (i_clock),
        .i_rst                      (i_rst),
        .i_pc_reset                 (i_pc_reset),
        .i_if_id                    (if_id),
        .i_ex_fwd                   (ex_fwd),
        .i_wb_wr                    (wb_wr),
        .i_debug_read_reg_address   (i_debug_read_reg_address),
        .o_debug_read_reg           (o_debug_read_reg),
        .o_id_ex                    (id_ex)
    );

    execution u_execution (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_pc_reset (i_pc_reset),
        .i_id_ex    (id_ex),
        .o_ex_fwd   (ex_fwd),
        .o_ex_wb    (ex_wb)
    );

    write_back u_write_back (
        .i_clock            (i_clock),
        .i_rst              (i_rst),
        .i_pc_reset         (i_pc_reset),
        .i_ex_wb            (ex_wb),
        .o_wb_wr            (wb_wr),
        .o_is_program_end   (o_is_program_end)
    );

endmodule

// File: verilog/write_back.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module write_back (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_pc_reset,
    input  mips_pkg::ex_wb_t    i_ex_wb,
    output mips_pkg::reg_wr_t   o_wb_wr,
    output logic                o_is_program_end
);

    logic halt_arrived;
    logic end_seen;     // Sticky until the next run

    // Register write, committed at the end of this cycle
    assign o_wb_wr.enable  = i_ex_wb.valid && i_ex_wb.reg_write;
    assign o_wb_wr.address = i_ex_wb.dest_addr;
    assign o_wb_wr.data    = i_ex_wb.result;

    // ------------------------------
    // Program end
    // ------------------------------
    assign halt_arrived = i_ex_wb.valid && i_ex_wb.halt;

    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            end_seen <= 1'b0;
        end else if (halt_arrived) begin
            end_seen <= 1'b1;
        end
    end

    // High from the cycle the halt reaches result
    assign o_is_program_end = end_seen || halt_arrived;

endmodule

// File: verilog/execution.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module execution (
    input  logic                i_clock,
    input  logic                i_rst,
    input  logic                i_pc_reset,
    input  mips_pkg::id_ex_t    i_id_ex,
    output mips_pkg::reg_wr_t   o_ex_fwd,
    output mips_pkg::ex_wb_t    o_ex_wb
);

    logic [`MIPS_NB_DATA-1:0] operand_b;
    logic [`MIPS_NB_DATA-1:0] alu_result;

    // ------------------------------
    // ALU
    // ------------------------------
    assign operand_b = i_id_ex.alu_src ? i_id_ex.imm : i_id_ex.op_b;

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_ADD: alu_result = i_id_ex.op_a + operand_b;
            mips_pkg::ALU_SUB: alu_result = i_id_ex.op_a - operand_b;
            mips_pkg::ALU_AND: alu_result = i_id_ex.op_a & operand_b;
            mips_pkg::ALU_OR:  alu_result = i_id_ex.op_a | operand_b;
            mips_pkg::ALU_XOR: alu_result = i_id_ex.op_a ^ operand_b;
            mips_pkg::ALU_SLT: begin
                alu_result = {{(`MIPS_NB_DATA-1){1'b0}},
                              ($signed(i_id_ex.op_a) < $signed(operand_b))};
            end
            default:           alu_result = '0;
        endcase
    end

    // Same cycle result back to decode
    assign o_ex_fwd.enable  = i_id_ex.valid && i_id_ex.reg_write;
    assign o_ex_fwd.address = i_id_ex.dest_addr;
    assign o_ex_fwd.data    = alu_result;

    // EX/WB register
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            o_ex_wb.valid     <= 1'b0;
            o_ex_wb.halt      <= 1'b0;
            o_ex_wb.reg_write <= 1'b0;
        end else begin
            o_ex_wb.valid     <= i_id_ex.valid;
            o_ex_wb.halt      <= i_id_ex.valid && i_id_ex.halt;
            o_ex_wb.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
        end
        o_ex_wb.dest_addr <= i_id_ex.dest_addr;
        o_ex_wb.result    <= alu_result;
    end

endmodule

// File: verilog/instruction_decode.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module instruction_decode (
    input  logic                            i_clock,
    input  logic                            i_rst,
    input  logic                            i_pc_reset,
    input  mips_pkg::if_id_t                i_if_id,
    input  mips_pkg::reg_wr_t               i_ex_fwd,   // Result now in execute
    input  mips_pkg::reg_wr_t               i_wb_wr,    // Write now in result
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_debug_read_reg_address,
    output logic [`MIPS_NB_DATA-1:0]        o_debug_read_reg,
    output mips_pkg::id_ex_t                o_id_ex
);

    logic [5:0]                     opcode;
    logic [5:0]                     funct;
    logic [`MIPS_NB_REG_ADDR-1:0]   rs_addr;
    logic [`MIPS_NB_REG_ADDR-1:0]   rt_addr;
    logic [`MIPS_NB_REG_ADDR-1:0]   rd_addr;
    logic [15:0]                    imm16;
    logic [`MIPS_NB_DATA-1:0]       rs_rf;
    logic [`MIPS_NB_DATA-1:0]       rt_rf;
    logic [`MIPS_NB_DATA-1:0]       rs_val;
    logic [`MIPS_NB_DATA-1:0]       rt_val;
    logic                           known;          // Low turns the word into a no-op
    logic                           reg_write;
    logic                           alu_src;
    mips_pkg::alu_op_t              alu_op;
    logic [`MIPS_NB_REG_ADDR-1:0]   dest_addr;
    logic [`MIPS_NB_DATA-1:0]       imm_ext;

    // Field split
    assign opcode  = i_if_id.instruction[31:26];
    assign rs_addr = i_if_id.instruction[25:21];
    assign rt_addr = i_if_id.instruction[20:16];
    assign rd_addr = i_if_id.instruction[15:11];
    assign funct   = i_if_id.instruction[5:0];
    assign imm16   = i_if_id.instruction[15:0];

    register_file u_register_file (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_pc_reset     (i_pc_reset),
        .i_wr_en        (i_wb_wr.enable),
        .i_wr_addr      (i_wb_wr.address),
        .i_rs_addr      (rs_addr),
        .i_rt_addr      (rt_addr),
        .i_debug_addr   (i_debug_read_reg_address),
        .i_wr_data      (i_wb_wr.data),
        .o_rs_data      (rs_rf),
        .o_rt_data      (rt_rf),
        .o_debug_data   (o_debug_read_reg)
    );

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        known     = 1'b1;
        reg_write = 1'b1;
        alu_src   = 1'b0;
        alu_op    = mips_pkg::ALU_ADD;
        dest_addr = rd_addr;
        imm_ext   = {{16{imm16[15]}}, imm16};   // Sign extend by default
        case (opcode)
            `MIPS_OP_RTYPE: begin
                case (funct)
                    `MIPS_FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    `MIPS_FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    default:       known  = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                alu_src   = 1'b1;
                dest_addr = rt_addr;
            end
            `MIPS_OP_ANDI, `MIPS_OP_ORI: begin
                alu_src   = 1'b1;
                dest_addr = rt_addr;
                imm_ext   = {16'b0, imm16};         // Logical ops zero extend
                alu_op    = (opcode == `MIPS_OP_ANDI) ? mips_pkg::ALU_AND : mips_pkg::ALU_OR;
            end
            `MIPS_OP_HALT: reg_write = 1'b0;        // Travels down, writes nothing
            default:       known     = 1'b0;
        endcase
    end

    // ------------------------------
    // Operand forwarding
    // ------------------------------

    // Youngest producer wins, r0 is hardwired
    function automatic logic [`MIPS_NB_DATA-1:0] pick_operand(
        input logic [`MIPS_NB_REG_ADDR-1:0] addr,
        input logic [`MIPS_NB_DATA-1:0]     rf_data,
        input mips_pkg::reg_wr_t            ex_src,
        input mips_pkg::reg_wr_t            wb_src
    );
        logic [`MIPS_NB_DATA-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_src.enable && ex_src.address == addr) begin
            value = ex_src.data;
        end else if (wb_src.enable && wb_src.address == addr) begin
            value = wb_src.data;                    // Not yet in the register file
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign rs_val = pick_operand(rs_addr, rs_rf, i_ex_fwd, i_wb_wr);
    assign rt_val = pick_operand(rt_addr, rt_rf, i_ex_fwd, i_wb_wr);

    // ID/EX register
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            o_id_ex.valid     <= 1'b0;
            o_id_ex.halt      <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
        end else begin
            o_id_ex.valid     <= i_if_id.valid && known;
            o_id_ex.halt      <= i_if_id.valid && i_if_id.halt;
            o_id_ex.reg_write <= i_if_id.valid && known && reg_write;
        end
        o_id_ex.alu_src   <= alu_src;
        o_id_ex.alu_op    <= alu_op;
        o_id_ex.dest_addr <= dest_addr;
        o_id_ex.op_a      <= rs_val;
        o_id_ex.op_b      <= rt_val;
        o_id_ex.imm       <= imm_ext;
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module register_file (
    input  logic                            i_clock,
    input  logic                            i_rst,
    input  logic                            i_pc_reset,
    input  logic                            i_wr_en,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_wr_addr,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_rs_addr,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_rt_addr,
    input  logic [`MIPS_NB_REG_ADDR-1:0]    i_debug_addr,
    input  logic [`MIPS_NB_DATA-1:0]        i_wr_data,
    output logic [`MIPS_NB_DATA-1:0]        o_rs_data,
    output logic [`MIPS_NB_DATA-1:0]        o_rt_data,
    output logic [`MIPS_NB_DATA-1:0]        o_debug_data
);

    logic [`MIPS_NB_DATA-1:0] regs [2**`MIPS_NB_REG_ADDR];

    // Either reset empties the whole file
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            for (int i = 0; i < 2**`MIPS_NB_REG_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin  // r0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Asynchronous reads, old value during a write
    assign o_rs_data    = regs[i_rs_addr];
    assign o_rt_data    = regs[i_rt_addr];
    assign o_debug_data = regs[i_debug_addr];   // Debug sees no forwarding

endmodule

// File: verilog/instruction_fetch.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module instruction_fetch (
    input  logic                            i_clock,
    input  logic                            i_rst,
    input  logic                            i_pc_reset,
    input  logic                            i_delete_program,
    input  logic                            i_load_program_write_enable,
    input  logic [`MIPS_NB_BYTE-1:0]        i_load_program_byte,
    output mips_pkg::if_id_t                o_if_id
);

    logic [`MIPS_NB_DATA-1:0]       imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_NB_IMEM_ADDR-1:0]  wr_ptr;         // Word being assembled
    logic [1:0]                     byte_cnt;       // Bytes already in that word
    logic [1:0]                     byte_lane;
    logic [`MIPS_NB_IMEM_ADDR-1:0]  pc;             // Word PC
    logic                           halted;
    logic [`MIPS_NB_DATA-1:0]       fetch_word;
    logic                           fetch_is_halt;

    // ------------------------------
    // Program loader
    // ------------------------------

    // First byte lands in the top lane
    assign byte_lane = 2'd3 - byte_cnt;

    always_ff @(posedge i_clock) begin
        if (i_rst || i_delete_program) begin
            wr_ptr   <= '0;
            byte_cnt <= '0;
            for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
                imem[i] <= '0;      // Empty memory
            end
        end else if (i_load_program_write_enable) begin
            imem[wr_ptr][byte_lane*`MIPS_NB_BYTE +: `MIPS_NB_BYTE] <= i_load_program_byte;
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
                wr_ptr <= wr_ptr + 1'b1;    // Word complete
            end
        end
    end

    // ------------------------------
    // PC and fetch
    // ------------------------------
    assign fetch_word    = imem[pc];
    assign fetch_is_halt = (fetch_word[31:26] == `MIPS_OP_HALT);

    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (fetch_is_halt) begin
                halted <= 1'b1;             // PC frozen on the halt word
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            o_if_id.valid <= 1'b0;
            o_if_id.halt  <= 1'b0;
        end else begin
            // Bubbles once the halt has gone by
            o_if_id.valid <= !halted;
            o_if_id.halt  <= !halted && fetch_is_halt;
        end
        o_if_id.instruction <= fetch_word;  // Payload, no reset
    end

endmodule

// File: verilog/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    // ------------------------------
    // ALU operations
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT     // Signed compare, result 0 or 1
    } alu_op_t;

    // ------------------------------
    // Stage payloads
    // ------------------------------

    // Fetch to decode
    typedef struct packed {
        logic                           valid;
        logic                           halt;
        logic [`MIPS_NB_DATA-1:0]       instruction;
    } if_id_t;

    // Decode to execute
    typedef struct packed {
        logic                           valid;
        logic                           halt;
        logic                           reg_write;
        logic                           alu_src;        // 1 selects the immediate
        alu_op_t                        alu_op;
        logic [`MIPS_NB_REG_ADDR-1:0]   dest_addr;
        logic [`MIPS_NB_DATA-1:0]       op_a;
        logic [`MIPS_NB_DATA-1:0]       op_b;
        logic [`MIPS_NB_DATA-1:0]       imm;            // Already extended
    } id_ex_t;

    // Execute to result
    typedef struct packed {
        logic                           valid;
        logic                           halt;
        logic                           reg_write;
        logic [`MIPS_NB_REG_ADDR-1:0]   dest_addr;
        logic [`MIPS_NB_DATA-1:0]       result;
    } ex_wb_t;

    // Register write, also used as a forwarding source
    typedef struct packed {
        logic                           enable;
        logic [`MIPS_NB_REG_ADDR-1:0]   address;
        logic [`MIPS_NB_DATA-1:0]       data;
    } reg_wr_t;

endpackage

// File: verilog/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ------------------------------
// Widths and sizes
// ------------------------------
`define MIPS_NB_DATA            32      // Data and instruction word
`define MIPS_NB_BYTE            8       // Loader byte
`define MIPS_NB_REG_ADDR        5
`define MIPS_NB_IMEM_ADDR       6       // Word address into instruction memory
`define MIPS_IMEM_DEPTH         64

// ------------------------------
// Opcodes, bits 31:26
// ------------------------------
`define MIPS_OP_RTYPE           6'd0
`define MIPS_OP_ADDIU           6'd9
`define MIPS_OP_ANDI            6'd12
`define MIPS_OP_ORI             6'd13
`define MIPS_OP_HALT            6'd63   // All ones, stops fetch

// R-type function field, bits 5:0
`define MIPS_FN_ADDU            6'd33
`define MIPS_FN_SUBU            6'd35
`define MIPS_FN_AND             6'd36
`define MIPS_FN_OR              6'd37
`define MIPS_FN_XOR             6'd38
`define MIPS_FN_SLT             6'd42

`endif
